// File: hw/ucode_defines.svh
// Microcode loader widths and the character codes of the load file
`ifndef UCODE_DEFINES_SVH
`define UCODE_DEFINES_SVH

// Field and character widths
`define UC_WORD_W 16
`define UC_CHAR_W 7
`define UC_FIELD_BITS 6

// Control RAM and dispatch RAM geometry
`define CRAM_W 86
`define CRAM_ADR_W 11
`define DRAM_ADR_W 9
`define DRAM_ENTRY_W 15

// Data words per CRAM location and per DRAM even/odd pair
`define CRAM_WORDS_PER_ENTRY 6
`define DRAM_WORDS_PER_PAIR 3

// Separators and record letters, 7-bit ASCII
`define CH_COMMA 7'h2C
`define CH_NEWLINE 7'h0A
`define CH_RETURN 7'h0D
`define CH_SEMICOLON 7'h3B
`define CH_REC_Z 7'h5A
`define CH_REC_C 7'h43
`define CH_REC_D 7'h44

`endif

// File: hw/ucode_pkg.sv
// Shared types of the microcode loader datapath and its state machines
`default_nettype none

`include "ucode_defines.svh"

package ucode_pkg;

  // Plain vectors for the widths that carry a meaning
  typedef logic [`UC_CHAR_W-1:0] ascii_char_t;
  typedef logic [`UC_WORD_W-1:0] uc_word_t;
  // CRAM bit n lives at vector position 85-n
  typedef logic [`CRAM_W-1:0] cram_word_t;
  typedef logic [`CRAM_ADR_W-1:0] cram_adr_t;
  typedef logic [`DRAM_ADR_W-1:0] dram_adr_t;
  // From MSB: A(3) B(3) P(1) J1-J4(4) J7(1) J8-J10(3)
  typedef logic [`DRAM_ENTRY_W-1:0] dram_entry_t;

  // Record letter of the current line
  typedef enum logic [1:0] {
    REC_ZERO, REC_CRAM, REC_DRAM, REC_BAD
  } rec_type_t;

  // Position of a field within its line
  typedef enum logic [1:0] {
    FIELD_COUNT, FIELD_ADR, FIELD_DATA, FIELD_CKSUM
  } field_kind_t;

  // Character decoder FSM
  typedef enum logic [1:0] {
    ST_TYPE, ST_SPACE, ST_FIELDS, ST_SKIP
  } dec_state_t;

endpackage

`default_nettype wire

// File: hw/field_decoder.sv
// Field decoder, splits ASCIIized lines into typed 16-bit field strobes
`timescale 1ns/1ps
`default_nettype none

`include "ucode_defines.svh"

module field_decoder (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   char_valid,
  input  ucode_pkg::ascii_char_t char_data,
  output logic                   field_valid,
  output ucode_pkg::uc_word_t    field_value,
  output ucode_pkg::field_kind_t field_kind,
  output ucode_pkg::rec_type_t   rec_type
);
  import ucode_pkg::*;

  dec_state_t  state;
  // Value of the field being received
  uc_word_t    acc;
  // Field index in the line, saturates at 2 (first data field)
  logic [1:0]  field_idx;
  logic        is_comma;
  logic        is_newline;
  logic        is_return;
  field_kind_t next_kind;

  assign is_comma   = (char_data == `CH_COMMA);
  assign is_newline = (char_data == `CH_NEWLINE);
  assign is_return  = (char_data == `CH_RETURN);

  // Newline always closes the checksum, else position decides
  always_comb begin
    if (is_newline) next_kind = FIELD_CKSUM;
    else if (field_idx == 2'd0) next_kind = FIELD_COUNT;
    else if (field_idx == 2'd1) next_kind = FIELD_ADR;
    else next_kind = FIELD_DATA;
  end

  always_ff @(posedge clk) begin
    field_valid <= 1'b0;
    if (rst) begin
      state     <= ST_TYPE;
      rec_type  <= REC_BAD;
      field_idx <= 2'd0;
    end else if (char_valid) begin
      case (state)
        ST_TYPE: begin
          // Blank lines and stray returns are passed over
          if (char_data == `CH_SEMICOLON) begin
            state <= ST_SKIP;
          end else if (!is_newline && !is_return) begin
            state <= ST_SPACE;
            case (char_data)
              `CH_REC_Z: rec_type <= REC_ZERO;
              `CH_REC_C: rec_type <= REC_CRAM;
              `CH_REC_D: rec_type <= REC_DRAM;
              default:   rec_type <= REC_BAD;
            endcase
          end
        end
        ST_SPACE: begin
          // Second character is a don't-care separator
          field_idx <= 2'd0;
          acc       <= '0;
          state     <= is_newline ? ST_TYPE : ST_FIELDS;
        end
        ST_FIELDS: begin
          if (is_comma || is_newline) begin
            field_valid <= 1'b1;
            field_value <= acc;
            field_kind  <= next_kind;
            acc         <= '0;
            if (field_idx != 2'd2) field_idx <= field_idx + 2'd1;
            if (is_newline) state <= ST_TYPE;
          end else if (!is_return) begin
            // Un-ASCIIize, 6 payload bits per character, MS group first
            acc <= {acc[`UC_WORD_W-`UC_FIELD_BITS-1:0], char_data[`UC_FIELD_BITS-1:0]};
          end
        end
        ST_SKIP: begin
          if (is_newline) state <= ST_TYPE;
        end
        default: state <= ST_TYPE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/cram_word_builder.sv
// CRAM word builder, packs six data fields of a C record into 86 bits
`timescale 1ns/1ps
`default_nettype none

`include "ucode_defines.svh"

module cram_word_builder (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   field_valid,
  input  ucode_pkg::uc_word_t    field_value,
  input  ucode_pkg::field_kind_t field_kind,
  input  ucode_pkg::rec_type_t   rec_type,
  output logic                   cram_word_valid,
  output ucode_pkg::cram_word_t  cram_word
);
  import ucode_pkg::*;

  localparam logic [2:0] LAST_GRP = 3'(`CRAM_WORDS_PER_ENTRY - 1);

  // Index of the next data word within the current location
  logic [2:0] grp;
  logic       data_hit;
  logic       cksum_hit;

  assign data_hit  = field_valid && (rec_type == REC_CRAM) && (field_kind == FIELD_DATA);
  assign cksum_hit = field_valid && (field_kind == FIELD_CKSUM);

  always_ff @(posedge clk) begin
    if (rst) begin
      grp             <= '0;
      cram_word_valid <= 1'b0;
    end else begin
      cram_word_valid <= data_hit && (grp == LAST_GRP);
      // End of line drops a partial location
      if (cksum_hit) grp <= '0;
      else if (data_hit) grp <= (grp == LAST_GRP) ? 3'd0 : grp + 3'd1;
    end
  end

  ////////////////////////////////////////////////////
  // Slice placement, CRAM bit n at position 85-n and
  // the lowest numbered bit of each slice in the MSB
  always_ff @(posedge clk) begin
    if (data_hit) begin
      case (grp)
        3'd0:    cram_word[21:6]  <= field_value;
        3'd1:    cram_word[37:22] <= field_value;
        3'd2:    cram_word[53:38] <= field_value;
        3'd3:    cram_word[69:54] <= field_value;
        3'd4:    cram_word[85:70] <= field_value;
        // CALL and DISP, bits 80-85
        default: cram_word[5:0]   <= field_value[5:0];
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/dram_pair_builder.sv
// DRAM pair builder, scatters even, odd and common words into two entries
`timescale 1ns/1ps
`default_nettype none

`include "ucode_defines.svh"

module dram_pair_builder (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   field_valid,
  input  ucode_pkg::uc_word_t    field_value,
  input  ucode_pkg::field_kind_t field_kind,
  input  ucode_pkg::rec_type_t   rec_type,
  output logic                   dram_pair_valid,
  output ucode_pkg::dram_entry_t dram_even,
  output ucode_pkg::dram_entry_t dram_odd
);
  import ucode_pkg::*;

  localparam logic [1:0] LAST_GRP = 2'(`DRAM_WORDS_PER_PAIR - 1);

  logic [1:0] grp;
  logic       data_hit;
  logic       cksum_hit;
  // Held even and odd words until the common word arrives
  uc_word_t   even_w;
  uc_word_t   odd_w;

  // A, B, parity and J8-J10 from the own word, J1-J4 common, J7 shared
  function automatic dram_entry_t pack_entry(uc_word_t own, uc_word_t common, logic j7);
    return {own[13:11], own[10:8], own[5], common[3:0], j7, own[2:0]};
  endfunction

  assign data_hit  = field_valid && (rec_type == REC_DRAM) && (field_kind == FIELD_DATA);
  assign cksum_hit = field_valid && (field_kind == FIELD_CKSUM);

  always_ff @(posedge clk) begin
    if (rst) begin
      grp             <= '0;
      dram_pair_valid <= 1'b0;
    end else begin
      dram_pair_valid <= data_hit && (grp == LAST_GRP);
      if (cksum_hit) grp <= '0;
      else if (data_hit) grp <= (grp == LAST_GRP) ? 2'd0 : grp + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (data_hit) begin
      case (grp)
        2'd0: even_w <= field_value;
        2'd1: odd_w  <= field_value;
        default: begin
          // J7 is written by the odd word only, both entries see it
          dram_even <= pack_entry(even_w, field_value, odd_w[3]);
          dram_odd  <= pack_entry(odd_w, field_value, odd_w[3]);
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/load_sequencer.sv
// Load sequencer, RAM write addressing and per-line checksum verdict
`timescale 1ns/1ps
`default_nettype none

module load_sequencer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   field_valid,
  input  ucode_pkg::uc_word_t    field_value,
  input  ucode_pkg::field_kind_t field_kind,
  input  ucode_pkg::rec_type_t   rec_type,
  input  logic                   cram_word_valid,
  input  ucode_pkg::cram_word_t  cram_word,
  input  logic                   dram_pair_valid,
  input  ucode_pkg::dram_entry_t dram_even,
  input  ucode_pkg::dram_entry_t dram_odd,
  output logic                   cram_wr,
  output ucode_pkg::cram_adr_t   cram_adr,
  output ucode_pkg::cram_word_t  cram_data,
  output logic                   dram_wr,
  output ucode_pkg::dram_adr_t   dram_adr,
  output ucode_pkg::dram_entry_t dram_even_out,
  output ucode_pkg::dram_entry_t dram_odd_out,
  output logic                   line_done,
  output logic                   line_ok
);
  import ucode_pkg::*;

  // Running sum of the line, the checksum field makes it zero
  uc_word_t  line_sum;
  uc_word_t  line_total;
  uc_word_t  count_w;
  uc_word_t  data_cnt;
  // Next load address, DRAM uses the low bits
  cram_adr_t load_adr;
  logic      cksum_hit;

  assign line_total = line_sum + field_value;
  assign cksum_hit  = field_valid && (field_kind == FIELD_CKSUM);

  always_ff @(posedge clk) begin
    if (rst) begin
      cram_wr   <= 1'b0;
      dram_wr   <= 1'b0;
      line_done <= 1'b0;
      line_sum  <= '0;
      count_w   <= '0;
      data_cnt  <= '0;
      load_adr  <= '0;
    end else begin
      cram_wr   <= cram_word_valid;
      dram_wr   <= dram_pair_valid;
      line_done <= cksum_hit;
      // One CRAM location or one DRAM even/odd pair per write
      if (cram_word_valid) load_adr <= load_adr + cram_adr_t'(1);
      else if (dram_pair_valid) load_adr <= load_adr + cram_adr_t'(2);
      if (field_valid) begin
        if (field_kind == FIELD_CKSUM) begin
          line_sum <= '0;
          count_w  <= '0;
          data_cnt <= '0;
        end else begin
          line_sum <= line_total;
          case (field_kind)
            FIELD_COUNT: count_w  <= field_value;
            FIELD_ADR:   load_adr <= cram_adr_t'(field_value);
            default:     data_cnt <= data_cnt + uc_word_t'(1);
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////
  // Write payload and verdict
  always_ff @(posedge clk) begin
    if (cram_word_valid) begin
      cram_adr  <= load_adr;
      cram_data <= cram_word;
    end
    if (dram_pair_valid) begin
      dram_adr      <= dram_adr_t'(load_adr);
      dram_even_out <= dram_even;
      dram_odd_out  <= dram_odd;
    end
    // Good line: zero sum, matching count, known record letter
    if (cksum_hit) begin
      line_ok <= (line_total == '0) && (data_cnt == count_w) && (rec_type != REC_BAD);
    end
  end

endmodule

`default_nettype wire

// File: hw/ucode_loader.sv
// Microcode loader top, character stream in, CRAM and DRAM writes out
`timescale 1ns/1ps
`default_nettype none

module ucode_loader (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   char_valid,
  input  ucode_pkg::ascii_char_t char_data,
  output logic                   cram_wr,
  output ucode_pkg::cram_adr_t   cram_adr,
  output ucode_pkg::cram_word_t  cram_data,
  output logic                   dram_wr,
  output ucode_pkg::dram_adr_t   dram_adr,
  output ucode_pkg::dram_entry_t dram_even,
  output ucode_pkg::dram_entry_t dram_odd,
  output logic                   line_done,
  output logic                   line_ok
);
  import ucode_pkg::*;

  // Decoded field strobe, fanned out to both builders and the sequencer
  logic        field_valid;
  uc_word_t    field_value;
  field_kind_t field_kind;
  rec_type_t   rec_type;
  logic        cram_word_valid;
  cram_word_t  cram_word;
  logic        dram_pair_valid;
  dram_entry_t pair_even;
  dram_entry_t pair_odd;

  field_decoder field_decoder_inst (.*);

  cram_word_builder cram_word_builder_inst (.*);

  dram_pair_builder dram_pair_builder_inst (.clk, .rst, .field_valid, .field_value,
    .field_kind, .rec_type, .dram_pair_valid, .dram_even(pair_even), .dram_odd(pair_odd));

  load_sequencer load_sequencer_inst (.clk, .rst, .field_valid, .field_value, .field_kind,
    .rec_type, .cram_word_valid, .cram_word, .dram_pair_valid, .dram_even(pair_even),
    .dram_odd(pair_odd), .cram_wr, .cram_adr, .cram_data, .dram_wr, .dram_adr,
    .dram_even_out(dram_even), .dram_odd_out(dram_odd), .line_done, .line_ok);

endmodule

`default_nettype wire

// File: bench/ucode_loader_assert.sv
// Output strobe protocol assertions for the microcode loader top level
`timescale 1ns/1ps
`default_nettype none

module ucode_loader_assert (
  input logic clk,
  input logic rst,
  input logic cram_wr,
  input logic dram_wr,
  input logic line_done
);

  // Number of failed assertions
  int fail_cnt = 0;

  // Any output strobe of the top level
  logic any_strobe;

  assign any_strobe = cram_wr || dram_wr || line_done;

  // Strobes stay low through the last reset cycle and the first cycle after it
  quiet_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> !any_strobe ##1 !any_strobe)
    else begin
      $error("write or line strobe high in the cycle after reset");
      fail_cnt = fail_cnt + 1;
    end

  // CRAM and DRAM writes come from different record types
  one_write_at_a_time: assert property (@(posedge clk) disable iff (rst) !(cram_wr && dram_wr))
    else begin
      $error("cram_wr and dram_wr high together");
      fail_cnt = fail_cnt + 1;
    end

  // A line needs at least its letter, separator and newline
  line_done_single: assert property (@(posedge clk) disable iff (rst) line_done |=> !line_done)
    else begin
      $error("line_done high in two consecutive cycles");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind ucode_loader ucode_loader_assert ucode_loader_assert_inst (.*);

`default_nettype wire

// File: bench/ucode_loader_tb.sv
// Testbench for the microcode loader, random load lines against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "ucode_defines.svh"

module ucode_loader_tb;
  import ucode_pkg::*;

  logic        clk;
  logic        rst;
  logic        char_valid;
  ascii_char_t char_data;
  logic        cram_wr;
  cram_adr_t   cram_adr;
  cram_word_t  cram_data;
  logic        dram_wr;
  dram_adr_t   dram_adr;
  dram_entry_t dram_even;
  dram_entry_t dram_odd;
  logic        line_done;
  logic        line_ok;

  int seed;
  int cyc = 0;
  // Cycle of the most recent character strobe
  int last_cyc;
  int err_cnt = 0;
  int chk_cnt = 0;

  // Expected results, in DUT output order
  cram_adr_t   exp_cram_adr[$];
  cram_word_t  exp_cram_data[$];
  int          exp_cram_cyc[$];
  dram_adr_t   exp_dram_adr[$];
  dram_entry_t exp_dram_even[$];
  dram_entry_t exp_dram_odd[$];
  int          exp_dram_cyc[$];
  logic        exp_ok[$];
  int          exp_line_cyc[$];

  ucode_loader ucode_loader_inst (.clk, .rst, .char_valid, .char_data, .cram_wr, .cram_adr,
    .cram_data, .dram_wr, .dram_adr, .dram_even, .dram_odd, .line_done, .line_ok);

  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'({$random(seed)} % (hi - lo + 1));
  endfunction

  // ASCIIize one 6-bit group, octal 75 to 77 pass as they are
  function automatic ascii_char_t encode_group(input logic [5:0] grp);
    if (grp < 6'o75) return ascii_char_t'(grp) + 7'o100;
    return ascii_char_t'(grp);
  endfunction

  ////////////////////////////////////////////////////
  // Reference model of the RAM word layouts
  function automatic cram_word_t cram_model(input uc_word_t fq[$], input int base);
    cram_word_t c;
    int k;
    int b;
    c = '0;
    // Words 0-4 carry CRAM bits 64, 48, 32, 16 and 0 upward, MSB first
    for (k = 0; k < 5; k++) begin
      for (b = 0; b < 16; b++) c[85 - (64 - 16 * k + b)] = fq[base + k][15 - b];
    end
    // Bits 80-85 from the low 6 bits of word 5
    for (b = 0; b < 6; b++) c[85 - (80 + b)] = fq[base + 5][5 - b];
    return c;
  endfunction

  function automatic dram_entry_t dram_model(input uc_word_t own, input uc_word_t common,
                                             input logic j7);
    dram_entry_t e;
    e[14:12] = own[13:11];
    e[11:9]  = own[10:8];
    e[8]     = own[5];
    // J1-J4 shared from the common word
    e[7:4]   = common[3:0];
    e[3]     = j7;
    e[2:0]   = own[2:0];
    return e;
  endfunction

  ////////////////////////////////////////////////////
  // Result comparison
  task automatic check_cram(input cram_adr_t adr, input cram_word_t data, input cram_adr_t e_adr,
                            input cram_word_t e_data, input int at, input int e_at);
    chk_cnt++;
    if (adr !== e_adr || data !== e_data || at != e_at) begin
      $display("FAILED %0t: CRAM write adr %h data %h cycle %0d, expected %h %h cycle %0d",
               $time, adr, data, at, e_adr, e_data, e_at);
      err_cnt++;
    end
  endtask

  task automatic check_dram(input dram_adr_t adr, input dram_entry_t even, input dram_entry_t odd,
                            input dram_adr_t e_adr, input dram_entry_t e_even,
                            input dram_entry_t e_odd, input int at, input int e_at);
    chk_cnt++;
    if (adr !== e_adr || even !== e_even || odd !== e_odd || at != e_at) begin
      $display("FAILED %0t: DRAM write adr %h even %h odd %h cycle %0d, expected %h %h %h cycle %0d",
               $time, adr, even, odd, at, e_adr, e_even, e_odd, e_at);
      err_cnt++;
    end
  endtask

  task automatic check_line(input logic ok, input logic e_ok, input int at, input int e_at);
    chk_cnt++;
    if (ok !== e_ok || at != e_at) begin
      $display("FAILED %0t: line_ok %b in cycle %0d, expected %b in cycle %0d",
               $time, ok, at, e_ok, e_at);
      err_cnt++;
    end
  endtask

  // Scoreboard, outputs sampled away from the active clock edge
  always @(negedge clk) begin
    if (!rst && cram_wr) begin
      if (exp_cram_adr.size() == 0) begin
        $display("Unexpected CRAM write at %0t", $time);
        err_cnt++;
      end else begin
        check_cram(cram_adr, cram_data, exp_cram_adr.pop_front(), exp_cram_data.pop_front(),
                   cyc, exp_cram_cyc.pop_front());
      end
    end
    if (!rst && dram_wr) begin
      if (exp_dram_adr.size() == 0) begin
        $display("Unexpected DRAM write at %0t", $time);
        err_cnt++;
      end else begin
        check_dram(dram_adr, dram_even, dram_odd, exp_dram_adr.pop_front(),
                   exp_dram_even.pop_front(), exp_dram_odd.pop_front(), cyc,
                   exp_dram_cyc.pop_front());
      end
    end
    if (!rst && line_done) begin
      if (exp_ok.size() == 0) begin
        $display("Unexpected line_done at %0t", $time);
        err_cnt++;
      end else begin
        check_line(line_ok, exp_ok.pop_front(), cyc, exp_line_cyc.pop_front());
      end
    end
  end

  ////////////////////////////////////////////////////
  // Character stream encoder
  task automatic drive_char(input ascii_char_t c, input bit gaps);
    int g;
    g = gaps ? rand_range(0, 3) : 0;
    repeat (g) begin
      @(negedge clk);
      char_valid = 1'b0;
    end
    @(negedge clk);
    char_valid = 1'b1;
    char_data  = c;
    last_cyc   = cyc;
  endtask

  // Shortest form, leading zero groups dropped, zero is empty
  task automatic send_field(input uc_word_t v, input bit gaps);
    int n;
    int g;
    n = (v[15:12] != 0) ? 3 : (v[11:6] != 0) ? 2 : (v[5:0] != 0) ? 1 : 0;
    for (g = n - 1; g >= 0; g--) drive_char(encode_group(6'(v >> (6 * g))), gaps);
  endtask

  // fault 1 corrupts the checksum, fault 2 the count
  task automatic send_record(input ascii_char_t letter, input int n_units, input int fault,
                             input bit gaps);
    uc_word_t fields[$];
    uc_word_t sum;
    uc_word_t adr;
    int per_unit;
    int n_data;
    int i;
    int d;
    bit is_c;
    bit is_d;
    is_c     = (letter == `CH_REC_C);
    is_d     = (letter == `CH_REC_D);
    per_unit = is_c ? 6 : is_d ? 3 : 1;
    n_data   = n_units * per_unit;
    // No units means the all-empty end-of-file line
    adr = (n_units == 0) ? '0 : uc_word_t'($random(seed));
    fields.push_back(uc_word_t'(n_data + ((fault == 2) ? 1 : 0)));
    fields.push_back(adr);
    for (i = 0; i < n_data; i++) fields.push_back(uc_word_t'($random(seed)));
    sum = '0;
    for (i = 0; i < fields.size(); i++) sum = sum + fields[i];
    sum = uc_word_t'(0) - sum;
    if (fault == 1) sum = sum + uc_word_t'(1);
    fields.push_back(sum);
    for (i = 0; i < n_units; i++) begin
      d = 2 + per_unit * i;
      if (is_c) begin
        exp_cram_adr.push_back(cram_adr_t'(adr + uc_word_t'(i)));
        exp_cram_data.push_back(cram_model(fields, d));
      end else if (is_d) begin
        exp_dram_adr.push_back(dram_adr_t'(adr + uc_word_t'(2 * i)));
        exp_dram_even.push_back(dram_model(fields[d], fields[d + 2], fields[d + 1][3]));
        exp_dram_odd.push_back(dram_model(fields[d + 1], fields[d + 2], fields[d + 1][3]));
      end
    end
    exp_ok.push_back(fault == 0 && (is_c || is_d || letter == `CH_REC_Z));
    drive_char(letter, gaps);
    drive_char(7'h20, gaps);
    for (i = 0; i < fields.size(); i++) begin
      send_field(fields[i], gaps);
      if (i == fields.size() - 1) begin
        // Stray return before the newline is ignored
        if (rand_range(0, 1) == 1) drive_char(`CH_RETURN, gaps);
        drive_char(`CH_NEWLINE, gaps);
        exp_line_cyc.push_back(last_cyc + 2);
      end else begin
        drive_char(`CH_COMMA, gaps);
        // Comma closing the last data word of a group
        if (i >= 2 && (i - 1) % per_unit == 0) begin
          if (is_c) exp_cram_cyc.push_back(last_cyc + 3);
          else if (is_d) exp_dram_cyc.push_back(last_cyc + 3);
        end
      end
    end
  endtask

  task automatic send_comment(input bit gaps);
    int i;
    drive_char(`CH_SEMICOLON, gaps);
    for (i = 0; i < 8; i++) drive_char(ascii_char_t'(7'h41 + rand_range(0, 25)), gaps);
    drive_char(`CH_NEWLINE, gaps);
  endtask

  // Idle the input, wait for all expected results, report the test
  task automatic finish_test(input string name, input int err_start);
    int t;
    @(negedge clk);
    char_valid = 1'b0;
    t = 0;
    while ((exp_cram_adr.size() != 0 || exp_dram_adr.size() != 0 || exp_ok.size() != 0)
           && t < 200) begin
      @(negedge clk);
      t++;
    end
    if (t >= 200) begin
      $display("Timeout in test %s, DUT results still missing", name);
      err_cnt++;
      exp_cram_adr.delete();
      exp_cram_data.delete();
      exp_cram_cyc.delete();
      exp_dram_adr.delete();
      exp_dram_even.delete();
      exp_dram_odd.delete();
      exp_dram_cyc.delete();
      exp_ok.delete();
      exp_line_cyc.delete();
    end
    repeat (4) @(negedge clk);
    $display("test %s done, %0d errors", name, err_cnt - err_start);
  endtask

  initial begin
    int err_start;
    seed       = 32'h3273_3fdd;
    clk        = 1'b0;
    rst        = 1'b1;
    char_valid = 1'b0;
    char_data  = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    err_start = err_cnt;
    repeat (6) send_record(`CH_REC_C, rand_range(1, 5), 0, 1'b1);
    finish_test("c_records", err_start);

    err_start = err_cnt;
    repeat (6) send_record(`CH_REC_D, rand_range(1, 10), 0, 1'b1);
    finish_test("d_records", err_start);

    err_start = err_cnt;
    send_record(`CH_REC_C, rand_range(1, 5), 1, 1'b1);
    send_record(`CH_REC_D, rand_range(1, 10), 1, 1'b1);
    finish_test("bad_checksum", err_start);

    err_start = err_cnt;
    send_record(`CH_REC_C, rand_range(1, 5), 2, 1'b1);
    send_record(`CH_REC_D, rand_range(1, 10), 2, 1'b1);
    finish_test("bad_count", err_start);

    err_start = err_cnt;
    send_comment(1'b1);
    send_record(`CH_REC_Z, 0, 0, 1'b1);
    send_record(`CH_REC_Z, 3, 0, 1'b1);
    send_record(7'h58, 2, 0, 1'b1);
    finish_test("special_lines", err_start);

    err_start = err_cnt;
    repeat (3) begin
      send_record(`CH_REC_C, rand_range(1, 5), 0, 1'b0);
      send_record(`CH_REC_D, rand_range(1, 10), 0, 1'b0);
    end
    finish_test("back_to_back", err_start);

    err_cnt = err_cnt + ucode_loader_inst.ucode_loader_assert_inst.fail_cnt;
    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+hw
hw/ucode_pkg.sv
hw/field_decoder.sv
hw/cram_word_builder.sv
hw/dram_pair_builder.sv
hw/load_sequencer.sv
hw/ucode_loader.sv
bench/ucode_loader_assert.sv
bench/ucode_loader_tb.sv
